// File: Makefile
# Verilator build and run of the SoC bus fabric testbench

SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
obj_dir/Vsoc_bus_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module soc_bus_tb -f verilog.f

# Pass or fail is taken from the simulator output
run: obj_dir/Vsoc_bus_tb
	@out=$$(./obj_dir/Vsoc_bus_tb 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf obj_dir

// File: dv/soc_bus_asserts.sv
/*
 * Concurrent assertions on the bus fabric, bound into soc_bus.
 * Checks decoder exclusivity, the idle serial line and memory ready.
 */
`default_nettype none

module soc_bus_asserts (
  input wire logic              i_clock,
  input wire logic              i_rst,
  input wire soc_pkg::bus_req_t i_rom_req,
  input wire soc_pkg::bus_req_t i_ram_req,
  input wire soc_pkg::bus_req_t i_led_req,
  input wire soc_pkg::bus_req_t i_uart_req,
  input wire soc_pkg::bus_rsp_t i_uart_rsp,
  input wire soc_pkg::bus_rsp_t i_rsp,
  input wire logic              i_uart_tx
);
  timeunit 1ns;
  timeprecision 1ps;

  // Windows do not overlap, so at most one target sees a request
  one_target: assert property (@(posedge i_clock) disable iff (i_rst)
    $onehot0({i_rom_req.req, i_ram_req.req, i_led_req.req, i_uart_req.req}))
    else $error("more than one target request is active");

  // Busy flag in bit 0 of the UART status
  tx_idle_high: assert property (@(posedge i_clock) disable iff (i_rst)
    !i_uart_rsp.rdata[0] |-> i_uart_tx)
    else $error("serial line is low while the UART is idle");

  mem_ready: assert property (@(posedge i_clock) disable iff (i_rst)
    (i_rom_req.req || i_ram_req.req) |-> i_rsp.ready)
    else $error("ROM or RAM access without ready");

endmodule

bind soc_bus soc_bus_asserts soc_bus_asserts_i (
  .i_clock    (i_clock),
  .i_rst      (i_rst),
  .i_rom_req  (rom_req),
  .i_ram_req  (ram_req),
  .i_led_req  (led_req),
  .i_uart_req (uart_req),
  .i_uart_rsp (uart_rsp),
  .i_rsp      (o_rsp),
  .i_uart_tx  (o_uart_tx)
);

`default_nettype wire

// File: dv/soc_bus_tb.sv
/*
 * Testbench for the SoC bus fabric. Acts as the bus master and runs ROM,
 * RAM, LED, UART and unmapped accesses, checking every result against
 * reference models. Built from verilog.f with soc_bus_tb as top.
 */
`default_nettype none

module soc_bus_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import soc_pkg::*;

  localparam int UART_BYTES = 4;
  localparam int LED_STEPS  = 40;
  localparam int RAM_WRITES = 200;
  localparam int unsigned TIMEOUT_CYCLES = UART_BYTES * 10 * CLKS_PER_BIT + 2000;

  logic     i_clock = 1'b0;
  logic     i_rst;
  bus_req_t i_req;
  bus_rsp_t o_rsp;
  led_t     o_leds;
  logic     o_uart_tx;

  data_t rom_model [ROM_WORDS];
  data_t ram_model [RAM_WORDS];
  led_t  led_model;
  addr_t ram_ofs_q [$];
  int unsigned cycles = 0;

  // Results waiting for the compare process
  data_t data_got_q [$];
  data_t data_exp_q [$];
  led_t  led_got_q [$];
  led_t  led_exp_q [$];
  byte_t byte_got_q [$];
  byte_t byte_exp_q [$];

  soc_bus soc_bus_i (
    .i_clock   (i_clock),
    .i_rst     (i_rst),
    .i_req     (i_req),
    .o_rsp     (o_rsp),
    .o_leds    (o_leds),
    .o_uart_tx (o_uart_tx)
  );

  always #10 i_clock = ~i_clock;

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_data(data_t got, data_t exp);
    if (got !== exp) begin
      $display("error at %0d ns: read data %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_leds(led_t got, led_t exp);
    if (got !== exp) begin
      $display("error at %0d ns: LED output %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("error at %0d ns: UART byte %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  // Word index is the offset divided by 4, modulo the memory size
  function automatic logic [ROM_IDX_W-1:0] rom_index(addr_t ofs);
    return ROM_IDX_W'((ofs / 4) % ROM_WORDS);
  endfunction

  function automatic logic [RAM_IDX_W-1:0] ram_index(addr_t ofs);
    return RAM_IDX_W'((ofs / 4) % RAM_WORDS);
  endfunction

  // Expected read data; LED window and unmapped space read as zero
  function automatic data_t ref_read(addr_t addr);
    if (addr >= ROM_BASE && addr < ROM_LIMIT) begin
      return rom_model[rom_index(addr - ROM_BASE)];
    end else if (addr >= RAM_BASE && addr < RAM_LIMIT) begin
      return ram_model[ram_index(addr - RAM_BASE)];
    end
    return '0;
  endfunction

  function automatic led_t led_ref(led_t cur, addr_t ofs, data_t wdata);
    led_t bits;
    bits = wdata[9:0];
    if (ofs == LED_OFS_WRITE) begin
      return bits;
    end else if (ofs == LED_OFS_SET) begin
      return cur | bits;
    end else if (ofs == LED_OFS_CLEAR) begin
      return cur & ~bits;
    end
    return cur;
  endfunction

  // Holds the request until ready is seen high before a rising edge
  task automatic bus_cycle(logic rw, addr_t addr, data_t wdata, output data_t rdata);
    logic done;
    done        = 1'b0;
    i_req.req   = 1'b1;
    i_req.rw    = rw;
    i_req.addr  = addr;
    i_req.wdata = wdata;
    while (!done) begin
      @(negedge i_clock);
      done  = o_rsp.ready;
      rdata = o_rsp.rdata;
      @(posedge i_clock);
      #1;
    end
    i_req = '0;
  endtask

  task automatic bus_write(addr_t addr, data_t wdata);
    data_t unused;
    bus_cycle(1'b1, addr, wdata, unused);
  endtask

  task automatic bus_read(addr_t addr, output data_t rdata);
    bus_cycle(1'b0, addr, '0, rdata);
  endtask

  task automatic expect_read(addr_t addr);
    data_t got;
    bus_read(addr, got);
    data_got_q.push_back(got);
    data_exp_q.push_back(ref_read(addr));
  endtask

  task automatic expect_leds();
    led_got_q.push_back(o_leds);
    led_exp_q.push_back(led_model);
  endtask

  initial begin : stimulus
    data_t got;
    data_t wdata;
    addr_t ofs;
    i_rst     = 1'b1;
    i_req     = '0;
    led_model = '0;
    void'($urandom(32'h5202bee7));
    $readmemh(ROM_FILE, rom_model);
    repeat (16) @(posedge i_clock);
    #1;
    i_rst = 1'b0;

    // LEDs dark after reset
    expect_leds();
    expect_read(LED_BASE);

    // Every ROM word, then one offset past the end that wraps
    for (int i = 0; i < ROM_WORDS; i++) begin
      expect_read(ROM_BASE + addr_t'(i) * 4);
    end
    expect_read(ROM_BASE + addr_t'(ROM_WORDS * 4 + 20));

    // Offsets span the whole window so the index wraps
    for (int i = 0; i < RAM_WRITES; i++) begin
      ofs   = addr_t'($urandom_range((RAM_LIMIT - RAM_BASE) / 4 - 1, 0)) * 4;
      wdata = $urandom;
      bus_write(RAM_BASE + ofs, wdata);
      ram_model[ram_index(ofs)] = wdata;
      ram_ofs_q.push_back(ofs);
    end
    for (int i = 0; i < RAM_WRITES; i++) begin
      expect_read(RAM_BASE + ram_ofs_q[$urandom_range(ram_ofs_q.size() - 1, 0)]);
    end

    // Offset 12 is outside the register set and must be ignored
    for (int i = 0; i < LED_STEPS; i++) begin
      ofs   = addr_t'($urandom_range(3, 0)) * 4;
      wdata = $urandom;
      bus_write(LED_BASE + ofs, wdata);
      led_model = led_ref(led_model, ofs, wdata);
      expect_leds();
    end

    // Later writes stall until the previous frame is out
    for (int i = 0; i < UART_BYTES; i++) begin
      wdata = $urandom;
      byte_exp_q.push_back(wdata[7:0]);
      bus_write(UART_BASE, wdata);
      bus_read(UART_BASE, got);
      data_got_q.push_back(got);
      data_exp_q.push_back(32'd1);
    end

    // Frame ends 10 bit periods after the last write was accepted
    repeat (10 * CLKS_PER_BIT - 2) @(posedge i_clock);
    #1;
    // Last cycle of the stop bit
    bus_read(UART_BASE, got);
    data_got_q.push_back(got);
    data_exp_q.push_back(32'd1);
    bus_read(UART_BASE, got);
    data_got_q.push_back(got);
    data_exp_q.push_back('0);

    // Unmapped space, with low bits aliasing a written RAM word
    expect_read(32'h3000_0000);
    bus_write(32'h3000_0000 + ram_ofs_q[0], $urandom);
    bus_write(32'h3000_0000 + LED_OFS_SET, 32'h0000_03ff);
    expect_leds();
    foreach (ram_ofs_q[i]) begin
      expect_read(RAM_BASE + ram_ofs_q[i]);
    end

    repeat (2) @(negedge i_clock);
    if (byte_exp_q.size() != 0 || byte_got_q.size() != 0) begin
      $display("UART sent %0d bytes fewer or more than were written",
               byte_exp_q.size() + byte_got_q.size());
      stop_run();
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  // Samples each bit near its middle, counted from the start-bit edge
  initial begin : uart_monitor
    byte_t rx;
    @(negedge i_rst);
    forever begin
      @(negedge o_uart_tx);
      repeat (CLKS_PER_BIT / 2) @(negedge i_clock);
      if (o_uart_tx !== 1'b0) begin
        $display("UART start bit at %0d ns did not stay low", $time);
        stop_run();
      end
      for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        rx[b] = o_uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge i_clock);
      if (o_uart_tx !== 1'b1) begin
        $display("UART stop bit at %0d ns is missing", $time);
        stop_run();
      end
      byte_got_q.push_back(rx);
    end
  end

  initial begin : compare
    forever begin
      @(negedge i_clock);
      while (data_got_q.size() > 0) begin
        check_data(data_got_q.pop_front(), data_exp_q.pop_front());
      end
      while (led_got_q.size() > 0) begin
        check_leds(led_got_q.pop_front(), led_exp_q.pop_front());
      end
      while (byte_got_q.size() > 0 && byte_exp_q.size() > 0) begin
        check_byte(byte_got_q.pop_front(), byte_exp_q.pop_front());
      end
    end
  end

  always @(posedge i_clock) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

endmodule

`default_nettype wire

// File: hw/boot_rom.sv
/*
 * Boot ROM with combinational read, filled from the ROM hex file.
 * Word index comes from the byte offset, wrapping at the ROM size.
 * Writes are ignored and the ROM is always ready.
 */
`default_nettype none

module boot_rom (
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_rsp_t      o_rsp
);
  import soc_pkg::*;

  data_t mem [ROM_WORDS];
  logic [ROM_IDX_W-1:0] rom_idx;

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  // Byte offset to word index
  assign rom_idx = i_req.addr[ROM_IDX_W+1:2];

  assign o_rsp.rdata = mem[rom_idx];
  assign o_rsp.ready = 1'b1;

endmodule

`default_nettype wire

// File: hw/bus_decode.sv
/*
 * Address decoder between the bus master and the four targets.
 * Steers the request by address window, removes the window base and
 * returns the response of the selected target. Unmapped accesses complete
 * at once with zero read data.
 */
`default_nettype none

module bus_decode (
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_req_t      o_rom_req,
  output soc_pkg::bus_req_t      o_ram_req,
  output soc_pkg::bus_req_t      o_led_req,
  output soc_pkg::bus_req_t      o_uart_req,
  input  wire soc_pkg::bus_rsp_t i_rom_rsp,
  input  wire soc_pkg::bus_rsp_t i_ram_rsp,
  input  wire soc_pkg::bus_rsp_t i_uart_rsp,
  output soc_pkg::bus_rsp_t      o_rsp
);
  import soc_pkg::*;

  logic rom_hit;
  logic ram_hit;
  logic led_hit;
  logic uart_hit;

  function automatic logic in_window(addr_t addr, addr_t base, addr_t limit);
    return (addr >= base) && (addr < limit);
  endfunction

  // Request copy for one target with its window base removed
  function automatic bus_req_t target_req(bus_req_t req, logic hit, addr_t base);
    bus_req_t t;
    t.req   = hit;
    t.rw    = req.rw;
    t.addr  = req.addr - base;
    t.wdata = req.wdata;
    return t;
  endfunction

  assign rom_hit  = i_req.req && in_window(i_req.addr, ROM_BASE, ROM_LIMIT);
  assign ram_hit  = i_req.req && in_window(i_req.addr, RAM_BASE, RAM_LIMIT);
  assign led_hit  = i_req.req && in_window(i_req.addr, LED_BASE, LED_LIMIT);
  assign uart_hit = i_req.req && in_window(i_req.addr, UART_BASE, UART_LIMIT);

  assign o_rom_req  = target_req(i_req, rom_hit, ROM_BASE);
  assign o_ram_req  = target_req(i_req, ram_hit, RAM_BASE);
  assign o_led_req  = target_req(i_req, led_hit, LED_BASE);
  assign o_uart_req = target_req(i_req, uart_hit, UART_BASE);

  // Response select, first hit wins
  always_comb begin
    o_rsp.rdata = '0;
    o_rsp.ready = 1'b1;
    if (rom_hit) begin
      o_rsp = i_rom_rsp;
    end else if (ram_hit) begin
      o_rsp = i_ram_rsp;
    end else if (led_hit) begin
      // Write-only register, always ready and reads as zero
      o_rsp.rdata = '0;
      o_rsp.ready = 1'b1;
    end else if (uart_hit) begin
      o_rsp = i_uart_rsp;
    end
  end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
/*
 * Data RAM of 32-bit words.
 * Read is combinational from the indexed word, a write is stored at the
 * clock edge of the accepted request. Always ready.
 */
`default_nettype none

module data_ram (
  input  wire logic              i_clock,
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_rsp_t      o_rsp
);
  import soc_pkg::*;

  data_t mem [RAM_WORDS];
  logic [RAM_IDX_W-1:0] ram_idx;
  logic wr_en;

  // Offset wraps at the RAM size
  assign ram_idx = i_req.addr[RAM_IDX_W+1:2];
  assign wr_en   = i_req.req && i_req.rw;

  always_ff @(posedge i_clock) begin
    if (wr_en) begin
      mem[ram_idx] <= i_req.wdata;
    end
  end

  assign o_rsp.rdata = mem[ram_idx];
  assign o_rsp.ready = 1'b1;

endmodule

`default_nettype wire

// File: hw/led_mapped.sv
/*
 * Memory-mapped LED register.
 * Writes at the write, set and clear offsets replace, OR in or clear
 * the LED bits. Reads are answered by the decoder.
 */
`default_nettype none

module led_mapped (
  input  wire logic              i_clock,
  input  wire logic              i_rst,
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::led_t          o_leds
);
  import soc_pkg::*;

  led_t leds_q;
  led_t wr_bits;

  assign wr_bits = i_req.wdata[9:0];

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      leds_q <= '0;
    end else if (i_req.req && i_req.rw) begin
      case (i_req.addr)
        LED_OFS_WRITE: leds_q <= wr_bits;
        LED_OFS_SET:   leds_q <= leds_q | wr_bits;
        LED_OFS_CLEAR: leds_q <= leds_q & ~wr_bits;
        default:       leds_q <= leds_q;
      endcase
    end
  end

  assign o_leds = leds_q;

endmodule

`default_nettype wire

// File: hw/rom_init.hex
// Boot ROM image: one 32-bit hex word per line, word 0 first
00000013
10000537
00050593
0005a603
00c5a023
00458593
fe0616e3
50000737
3ff00793
00f72023
a5a55a5a
12345678
deadbeef
0f0f0f0f
80000001
7fffffff

// File: hw/soc_bus.sv
/*
 * Top level of the bus fabric.
 * Connects the master port to the address decoder and the boot ROM,
 * data RAM, LED register and UART transmitter behind it.
 */
`default_nettype none

module soc_bus (
  input  wire logic              i_clock,
  input  wire logic              i_rst,
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_rsp_t      o_rsp,
  output soc_pkg::led_t          o_leds,
  output logic                   o_uart_tx
);
  import soc_pkg::*;

  // Per-target requests, base already removed
  bus_req_t rom_req;
  bus_req_t ram_req;
  bus_req_t led_req;
  bus_req_t uart_req;

  bus_rsp_t rom_rsp;
  bus_rsp_t ram_rsp;
  bus_rsp_t uart_rsp;

  bus_decode bus_decode_i (
    .i_req      (i_req),
    .o_rom_req  (rom_req),
    .o_ram_req  (ram_req),
    .o_led_req  (led_req),
    .o_uart_req (uart_req),
    .i_rom_rsp  (rom_rsp),
    .i_ram_rsp  (ram_rsp),
    .i_uart_rsp (uart_rsp),
    .o_rsp      (o_rsp)
  );

  boot_rom boot_rom_i (
    .i_req (rom_req),
    .o_rsp (rom_rsp)
  );

  data_ram data_ram_i (
    .i_clock (i_clock),
    .i_req   (ram_req),
    .o_rsp   (ram_rsp)
  );

  led_mapped led_mapped_i (
    .i_clock (i_clock),
    .i_rst   (i_rst),
    .i_req   (led_req),
    .o_leds  (o_leds)
  );

  uart_tx uart_tx_i (
    .i_clock   (i_clock),
    .i_rst     (i_rst),
    .i_req     (uart_req),
    .o_rsp     (uart_rsp),
    .o_uart_tx (o_uart_tx)
  );

endmodule

`default_nettype wire

// File: hw/soc_pkg.sv
/*
 * Shared definitions for the SoC bus fabric: address map, memory sizes,
 * bus request and response types and the UART transmitter states.
 * RTL modules import it inside their bodies and use scoped names in ports.
 */
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [9:0]  led_t;
  typedef logic [7:0]  byte_t;

  // One bus transfer from the master, rw = 1 means write
  typedef struct packed {
    logic  req;
    logic  rw;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  ready;
  } bus_rsp_t;

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_e;

  // Address windows, base inclusive and limit exclusive
  localparam addr_t ROM_BASE   = 32'h0000_0000;
  localparam addr_t ROM_LIMIT  = 32'h0001_0000;
  localparam addr_t RAM_BASE   = 32'h0001_0000;
  localparam addr_t RAM_LIMIT  = 32'h0002_0000;
  localparam addr_t LED_BASE   = 32'h5000_0000;
  localparam addr_t LED_LIMIT  = 32'h5000_0010;
  localparam addr_t UART_BASE  = 32'h5000_0010;
  localparam addr_t UART_LIMIT = 32'h5000_0020;

  localparam int ROM_WORDS = 256;
  localparam int RAM_WORDS = 1024;
  localparam int ROM_IDX_W = $clog2(ROM_WORDS);
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  localparam string ROM_FILE = "hw/rom_init.hex";

  // LED register offsets inside its window
  localparam addr_t LED_OFS_WRITE = 32'h0000_0000;
  localparam addr_t LED_OFS_SET   = 32'h0000_0004;
  localparam addr_t LED_OFS_CLEAR = 32'h0000_0008;

  // Baud divisor in clock cycles per serial bit
  localparam data_t CLKS_PER_BIT = 32'd16;
  localparam int    BIT_CNT_W    = $clog2(CLKS_PER_BIT);

endpackage

`default_nettype wire

// File: hw/uart_tx.sv
/*
 * Transmit-only UART, 8N1 with CLKS_PER_BIT clocks per bit.
 * A write while idle latches wdata[7:0] and starts a frame; a write while
 * busy is held off by ready low. Reads return the busy flag in bit 0.
 */
`default_nettype none

module uart_tx (
  input  wire logic              i_clock,
  input  wire logic              i_rst,
  input  wire soc_pkg::bus_req_t i_req,
  output soc_pkg::bus_rsp_t      o_rsp,
  output logic                   o_uart_tx
);
  import soc_pkg::*;

  localparam logic [BIT_CNT_W-1:0] LAST_CLK = BIT_CNT_W'(CLKS_PER_BIT - 1);

  uart_state_e          state;
  logic [BIT_CNT_W-1:0] clk_cnt;
  logic [2:0]           bit_idx;
  byte_t                shift_q;
  logic                 tx_q;
  logic                 busy;
  logic                 accept;
  logic                 bit_end;

  assign busy    = (state != IDLE);
  assign accept  = i_req.req && i_req.rw && !busy;
  assign bit_end = (clk_cnt == LAST_CLK);

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_q    <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            // Start bit goes out on the next cycle
            state   <= START;
            clk_cnt <= '0;
            tx_q    <= 1'b0;
          end
        end
        START: begin
          clk_cnt <= clk_cnt + 1'b1;
          if (bit_end) begin
            state   <= DATA;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_q    <= shift_q[0];
          end
        end
        DATA: begin
          clk_cnt <= clk_cnt + 1'b1;
          if (bit_end) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
              tx_q  <= 1'b1;
            end else begin
              tx_q <= shift_q[1];
            end
          end
        end
        STOP: begin
          clk_cnt <= clk_cnt + 1'b1;
          if (bit_end) begin
            state   <= IDLE;
            clk_cnt <= '0;
          end
        end
        default: begin
          state <= IDLE;
          tx_q  <= 1'b1;
        end
      endcase
    end
  end

  // Character shift register, LSB first
  always_ff @(posedge i_clock) begin
    if (accept) begin
      shift_q <= i_req.wdata[7:0];
    end else if (state == DATA && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  // Status reads never stall, writes wait for idle
  assign o_rsp.rdata = {31'b0, busy};
  assign o_rsp.ready = !(i_req.rw && busy);
  assign o_uart_tx   = tx_q;

endmodule

`default_nettype wire

// File: verilog.f
hw/soc_pkg.sv
hw/bus_decode.sv
hw/boot_rom.sv
hw/data_ram.sv
hw/led_mapped.sv
hw/uart_tx.sv
hw/soc_bus.sv
dv/soc_bus_asserts.sv
dv/soc_bus_tb.sv
